/* compile.f */
design/exec_pkg.sv
design/alu_core.sv
design/branch_unit.sv
design/next_pc_select.sv
design/exec_unit.sv
verif/tb_exec_unit.sv

/* design/alu_core.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_core (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              valid,
    input  exec_pkg::opcode_t                 opcode,
    input  logic [exec_pkg::data_width-1:0]   rs,
    input  logic [exec_pkg::data_width-1:0]   rt,
    output logic [exec_pkg::data_width-1:0]   result,
    output logic                              result_valid,
    output logic                              next_z,
    output logic                              next_c,
    output logic                              next_s,
    output logic                              next_o,
    output logic                              alu_op
);

    import exec_pkg::*;

    logic [data_width:0]   sum_ext;     // carry in top bit
    logic [data_width:0]   diff_ext;    // borrow in top bit
    logic [data_width-1:0] res_c;
    logic                  arith;       // opcode is in the arithmetic group
    logic                  carry_c;
    logic                  ovf_c;

    ////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////

    assign sum_ext  = {1'b0, rs} + {1'b0, rt};
    assign diff_ext = {1'b0, rs} - {1'b0, rt};

    always_comb
    begin
        res_c   = '0;
        carry_c = 1'b0;     // only add / sub produce carry
        ovf_c   = 1'b0;     // only add / sub produce overflow
        arith   = 1'b1;
        case (opcode)
            op_add:
            begin
                res_c   = sum_ext[data_width-1:0];
                carry_c = sum_ext[data_width];
                // same operand signs, result sign differs
                ovf_c   = (rs[data_width-1] == rt[data_width-1]) &&
                          (res_c[data_width-1] != rs[data_width-1]);
            end
            op_sub:
            begin
                res_c   = diff_ext[data_width-1:0];
                carry_c = diff_ext[data_width];     // borrow out
                // opposite operand signs, result sign flips from rs
                ovf_c   = (rs[data_width-1] != rt[data_width-1]) &&
                          (res_c[data_width-1] != rs[data_width-1]);
            end
            op_and:  res_c = rs & rt;
            op_or:   res_c = rs | rt;
            op_xor:  res_c = rs ^ rt;
            op_shl:  res_c = rs << rt[$clog2(data_width)-1:0];
            op_shr:  res_c = rs >> rt[$clog2(data_width)-1:0];   // zero fill
            default: arith = 1'b0;      // branch or no-op
        endcase
    end

    // flag candidates, latched by the branch unit
    assign next_z = (res_c == '0);
    assign next_s = res_c[data_width-1];
    assign next_c = carry_c;
    assign next_o = ovf_c;

    assign alu_op = valid && arith;

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            result       <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            result_valid <= alu_op;     // one-cycle pulse per instruction
            if (alu_op)
                result <= res_c;        // holds last result otherwise
        end
    end

    // no stray result pulses from branches or idle cycles
    a_no_spurious_result: assert property (
        @(posedge clk) disable iff (rst)
        result_valid |-> $past(valid) && !$past(opcode[$bits(opcode)-1])
    );

endmodule

`default_nettype wire

/* design/branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid,
    input  exec_pkg::opcode_t opcode,
    input  logic              alu_op,
    input  logic              next_z,
    input  logic              next_c,
    input  logic              next_s,
    input  logic              next_o,
    output logic              z_flag,
    output logic              c_flag,
    output logic              s_flag,
    output logic              o_flag,
    output logic              take,
    output logic              use_reg_target,
    output logic              is_call
);

    import exec_pkg::*;

    logic cond;     // branch condition met, before valid

    ////////////////////////////////////////////////////////////
    // flag registers
    ////////////////////////////////////////////////////////////

    // loaded only by arithmetic ops, branches and idles leave them alone
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            z_flag <= 1'b0;
            c_flag <= 1'b0;
            s_flag <= 1'b0;
            o_flag <= 1'b0;
        end
        else if (alu_op)
        begin
            z_flag <= next_z;
            c_flag <= next_c;
            s_flag <= next_s;
            o_flag <= next_o;
        end
    end

    ////////////////////////////////////////////////////////////
    // condition decode against held flags
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        cond           = 1'b0;
        use_reg_target = 1'b0;
        is_call        = 1'b0;
        case (opcode)
            op_jmp:  cond = 1'b1;
            op_jr:
            begin
                cond           = 1'b1;
                use_reg_target = 1'b1;  // target from rs
            end
            op_bz:   cond = z_flag;
            op_bnz:  cond = !z_flag;
            op_bc:   cond = c_flag;
            op_bnc:  cond = !c_flag;
            op_bs:   cond = s_flag;
            op_bns:  cond = !s_flag;
            op_bo:   cond = o_flag;
            op_bno:  cond = !o_flag;
            op_call:
            begin
                cond    = 1'b1;
                is_call = 1'b1;         // link written downstream
            end
            op_ret:
            begin
                cond           = 1'b1;
                use_reg_target = 1'b1;  // rs carries the saved link
            end
            default: cond = 1'b0;       // arithmetic and no-ops never branch
        endcase
    end

    assign take = valid && cond;

    // alu_op comes from the alu, take from the decode here
    a_take_not_arith: assert property (
        @(posedge clk) disable iff (rst)
        !(take && alu_op)
    );

endmodule

`default_nettype wire

/* design/exec_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////
// shared widths, reset value and opcode map
////////////////////////////////////////////////////////////

package exec_pkg;

    localparam int data_width = 32;        // operand / result width
    localparam int addr_width = 16;        // pc, immediate, branch target

    localparam logic [addr_width-1:0] pc_reset = 16'h0000;  // pc after reset

    // 6-bit opcode field of the instruction word
    // top bit clear -> arithmetic, top bit set -> branch group
    typedef enum logic [5:0]
    {
        // arithmetic and logic
        op_add  = 6'b000000,    // rs + rt
        op_sub  = 6'b000001,    // rs - rt
        op_and  = 6'b000010,
        op_or   = 6'b000011,
        op_xor  = 6'b000100,
        op_shl  = 6'b000101,    // shift left by rt[4:0]
        op_shr  = 6'b000110,    // logical shift right by rt[4:0]

        // unconditional transfers
        op_jmp  = 6'b100000,    // pc + imm
        op_jr   = 6'b100001,    // pc <= rs[15:0]

        // conditional on held flags
        op_bz   = 6'b100010,    // zero set
        op_bnz  = 6'b100011,    // zero clear
        op_bc   = 6'b100100,    // carry / borrow set
        op_bnc  = 6'b100101,
        op_bs   = 6'b100110,    // negative result
        op_bns  = 6'b100111,    // non-negative result
        op_bo   = 6'b101000,    // signed overflow
        op_bno  = 6'b101001,

        // subroutine linkage
        op_call = 6'b101010,    // pc + imm, link = old pc + 1
        op_ret  = 6'b101011     // pc <= rs[15:0], rs holds the link
    } opcode_t;

    // any encoding not listed is treated as a no-op:
    // no result, no flag update, pc just advances

endpackage

`default_nettype wire

/* design/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              valid,
    input  exec_pkg::opcode_t                 opcode,
    input  logic [exec_pkg::data_width-1:0]   rs,
    input  logic [exec_pkg::data_width-1:0]   rt,
    input  logic [exec_pkg::addr_width-1:0]   imm,
    output logic [exec_pkg::data_width-1:0]   result,
    output logic                              result_valid,
    output logic                              z_flag,
    output logic                              c_flag,
    output logic                              s_flag,
    output logic                              o_flag,
    output logic [exec_pkg::addr_width-1:0]   pc,
    output logic                              branch_taken,
    output logic [exec_pkg::addr_width-1:0]   link_addr,
    output logic                              link_valid
);

    // alu -> branch unit, flag candidates and load strobe
    logic next_z;
    logic next_c;
    logic next_s;
    logic next_o;
    logic alu_op;

    // branch unit -> pc select
    logic take;
    logic use_reg_target;
    logic is_call;

    ////////////////////////////////////////////////////////////
    // arithmetic unit
    ////////////////////////////////////////////////////////////

    alu_core alu_core_inst (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .opcode       (opcode),
        .rs           (rs),
        .rt           (rt),
        .result       (result),
        .result_valid (result_valid),
        .next_z       (next_z),
        .next_c       (next_c),
        .next_s       (next_s),
        .next_o       (next_o),
        .alu_op       (alu_op)
    );

    ////////////////////////////////////////////////////////////
    // flag hold + branch decision
    ////////////////////////////////////////////////////////////

    branch_unit branch_unit_inst (
        .clk            (clk),
        .rst            (rst),
        .valid          (valid),
        .opcode         (opcode),
        .alu_op         (alu_op),
        .next_z         (next_z),
        .next_c         (next_c),
        .next_s         (next_s),
        .next_o         (next_o),
        .z_flag         (z_flag),
        .c_flag         (c_flag),
        .s_flag         (s_flag),
        .o_flag         (o_flag),
        .take           (take),
        .use_reg_target (use_reg_target),
        .is_call        (is_call)
    );

    // program counter and call link
    next_pc_select next_pc_select_inst (
        .clk            (clk),
        .rst            (rst),
        .valid          (valid),
        .take           (take),
        .use_reg_target (use_reg_target),
        .is_call        (is_call),
        .rs             (rs),
        .imm            (imm),
        .pc             (pc),
        .branch_taken   (branch_taken),
        .link_addr      (link_addr),
        .link_valid     (link_valid)
    );

endmodule

`default_nettype wire

/* design/next_pc_select.sv */
`timescale 1ns/1ns
`default_nettype none

module next_pc_select (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              valid,
    input  logic                              take,
    input  logic                              use_reg_target,
    input  logic                              is_call,
    input  logic [exec_pkg::data_width-1:0]   rs,
    input  logic [exec_pkg::addr_width-1:0]   imm,
    output logic [exec_pkg::addr_width-1:0]   pc,
    output logic                              branch_taken,
    output logic [exec_pkg::addr_width-1:0]   link_addr,
    output logic                              link_valid
);

    import exec_pkg::*;

    logic [addr_width-1:0] pc_next;     // pc after the current instruction
    logic [addr_width-1:0] pc_inc;      // fall-through, doubles as call link

    assign pc_inc = pc + addr_width'(1);

    ////////////////////////////////////////////////////////////
    // next pc choice
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        if (take && use_reg_target)
            pc_next = rs[addr_width-1:0];   // jr / ret
        else if (take)
            pc_next = pc + imm;             // relative, wraps at 16 bits
        else
            pc_next = pc_inc;               // untaken branch, arithmetic, no-op
    end

    ////////////////////////////////////////////////////////////
    // pc, branch pulse and call link
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pc           <= pc_reset;
            branch_taken <= 1'b0;
            link_addr    <= '0;
            link_valid   <= 1'b0;
        end
        else
        begin
            branch_taken <= take;           // take already includes valid
            link_valid   <= take && is_call;
            if (valid)
                pc <= pc_next;              // idle cycles hold pc
            if (take && is_call)
                link_addr <= pc_inc;        // return lands after the call
        end
    end

    // a call is always a taken, imm-relative transfer
    a_link_implies_taken: assert property (
        @(posedge clk) disable iff (rst)
        link_valid |-> branch_taken && (pc == $past(pc) + $past(imm))
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the exec_unit testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_exec_unit -f compile.f -o tb_exec_unit_sim

sim_out=$(./obj_dir/tb_exec_unit_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

/* verif/tb_exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_exec_unit;

    import exec_pkg::*;

    // cycles per test, issue slots plus drain
    localparam int reset_cycles  = 8;
    localparam int arith_cycles  = 203;
    localparam int cond_cycles   = 27;
    localparam int uncond_cycles = 11;
    localparam int call_cycles   = 11;
    localparam int hold_cycles   = 16;
    localparam int cycle_limit   = reset_cycles + arith_cycles + cond_cycles
                                 + uncond_cycles + call_cycles + hold_cycles + 50;

    logic                  clk;
    logic                  rst;
    logic                  valid;
    opcode_t               opcode;
    logic [data_width-1:0] rs;
    logic [data_width-1:0] rt;
    logic [addr_width-1:0] imm;

    logic [data_width-1:0] result;
    logic                  result_valid;
    logic                  z_flag;
    logic                  c_flag;
    logic                  s_flag;
    logic                  o_flag;
    logic [addr_width-1:0] pc;
    logic                  branch_taken;
    logic [addr_width-1:0] link_addr;
    logic                  link_valid;

    // reference model state
    logic [data_width-1:0] m_result;
    logic                  m_result_valid;
    logic                  m_z;
    logic                  m_c;
    logic                  m_s;
    logic                  m_o;
    logic [addr_width-1:0] m_pc;
    logic                  m_branch_taken;
    logic [addr_width-1:0] m_link_addr;
    logic                  m_link_valid;

    logic [31:0] rng_state   = 32'h5c25_270e;
    int          err_count   = 0;
    int          test_errs   = 0;   // err_count at test start
    int          tests_ok    = 0;
    int          tests_bad   = 0;
    int          cycle_count = 0;

    exec_unit exec_unit_inst (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .opcode       (opcode),
        .rs           (rs),
        .rt           (rt),
        .imm          (imm),
        .result       (result),
        .result_valid (result_valid),
        .z_flag       (z_flag),
        .c_flag       (c_flag),
        .s_flag       (s_flag),
        .o_flag       (o_flag),
        .pc           (pc),
        .branch_taken (branch_taken),
        .link_addr    (link_addr),
        .link_valid   (link_valid)
    );

    always #2 clk = ~clk;   // 4 ns period

    ////////////////////////////////////////////////////////////
    // random source and reference rules
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic is_arith(input opcode_t op);
        return op inside {op_add, op_sub, op_and, op_or, op_xor, op_shl, op_shr};
    endfunction

    function automatic logic [31:0] expected_result(input opcode_t op,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_shl:  return a << b[4:0];
            op_shr:  return a >> b[4:0];
            default: return 32'h0;
        endcase
    endfunction

    // carry out of add shows up as wraparound, borrow as a < b
    function automatic logic expected_carry(input opcode_t op,
                                            input logic [31:0] a,
                                            input logic [31:0] b);
        logic [31:0] sum;
        sum = a + b;
        if (op == op_add)
            return sum < a;
        if (op == op_sub)
            return a < b;
        return 1'b0;
    endfunction

    // overflow when the wide signed answer does not fit 32 bits
    function automatic logic expected_overflow(input opcode_t op,
                                               input logic [31:0] a,
                                               input logic [31:0] b);
        longint wide;
        wide = 0;
        if (op == op_add)
            wide = longint'($signed(a)) + longint'($signed(b));
        else if (op == op_sub)
            wide = longint'($signed(a)) - longint'($signed(b));
        return wide != longint'($signed(wide[31:0]));
    endfunction

    // taken decision on the flags held before this edge
    function automatic logic branch_cond(input opcode_t op);
        case (op)
            op_jmp, op_jr, op_call, op_ret: return 1'b1;
            op_bz:   return m_z;
            op_bnz:  return !m_z;
            op_bc:   return m_c;
            op_bnc:  return !m_c;
            op_bs:   return m_s;
            op_bns:  return !m_s;
            op_bo:   return m_o;
            op_bno:  return !m_o;
            default: return 1'b0;
        endcase
    endfunction

    always @(posedge clk or posedge rst)
    begin : model_update
        logic [31:0] res;
        if (rst)
        begin
            m_result       <= '0;
            m_result_valid <= 1'b0;
            {m_z, m_c, m_s, m_o} <= 4'b0000;
            m_pc           <= pc_reset;
            m_branch_taken <= 1'b0;
            m_link_addr    <= '0;
            m_link_valid   <= 1'b0;
        end
        else
        begin
            m_result_valid <= valid && is_arith(opcode);
            m_branch_taken <= 1'b0;
            m_link_valid   <= 1'b0;
            if (valid && is_arith(opcode))
            begin
                res = expected_result(opcode, rs, rt);
                m_result <= res;
                m_z      <= (res == 32'h0);
                m_s      <= res[31];
                m_c      <= expected_carry(opcode, rs, rt);
                m_o      <= expected_overflow(opcode, rs, rt);
                m_pc     <= m_pc + 16'd1;
            end
            else if (valid && branch_cond(opcode))
            begin
                m_branch_taken <= 1'b1;
                if (opcode == op_jr || opcode == op_ret)
                    m_pc <= rs[15:0];       // register target
                else
                    m_pc <= m_pc + imm;     // wraps at 16 bits
                if (opcode == op_call)
                begin
                    m_link_valid <= 1'b1;
                    m_link_addr  <= m_pc + 16'd1;
                end
            end
            else if (valid)
                m_pc <= m_pc + 16'd1;       // untaken branch or no-op
        end
    end

    ////////////////////////////////////////////////////////////
    // checks, sampled mid-cycle
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH %s: got %h expected %h", name, got, exp);
        err_count++;
    endtask

    task automatic report_error(input string what);
        $display("error: %s", what);
        err_count++;
    endtask

    chk_pc: assert property (@(negedge clk) disable iff (rst) pc == m_pc)
        else report_mismatch("pc", 32'(pc), 32'(m_pc));
    chk_result_valid: assert property (@(negedge clk) disable iff (rst)
        result_valid == m_result_valid)
        else report_mismatch("result_valid", 32'(result_valid), 32'(m_result_valid));
    chk_result: assert property (@(negedge clk) disable iff (rst)
        m_result_valid |-> result == m_result)
        else report_mismatch("result", result, m_result);
    chk_z: assert property (@(negedge clk) disable iff (rst) z_flag == m_z)
        else report_mismatch("z_flag", 32'(z_flag), 32'(m_z));
    chk_c: assert property (@(negedge clk) disable iff (rst) c_flag == m_c)
        else report_mismatch("c_flag", 32'(c_flag), 32'(m_c));
    chk_s: assert property (@(negedge clk) disable iff (rst) s_flag == m_s)
        else report_mismatch("s_flag", 32'(s_flag), 32'(m_s));
    chk_o: assert property (@(negedge clk) disable iff (rst) o_flag == m_o)
        else report_mismatch("o_flag", 32'(o_flag), 32'(m_o));
    chk_branch_taken: assert property (@(negedge clk) disable iff (rst)
        branch_taken == m_branch_taken)
        else report_mismatch("branch_taken", 32'(branch_taken), 32'(m_branch_taken));
    chk_link_valid: assert property (@(negedge clk) disable iff (rst)
        link_valid == m_link_valid)
        else report_mismatch("link_valid", 32'(link_valid), 32'(m_link_valid));
    chk_link_addr: assert property (@(negedge clk) disable iff (rst)
        m_link_valid |-> link_addr == m_link_addr)
        else report_mismatch("link_addr", 32'(link_addr), 32'(m_link_addr));
    chk_pc_idle: assert property (@(negedge clk) disable iff (rst)
        !valid |=> $stable(pc))
        else report_error("pc moved during a cycle with valid low");
    chk_link_branch: assert property (@(negedge clk) disable iff (rst)
        link_valid |-> branch_taken)
        else report_error("link_valid pulsed without branch_taken");

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic issue_instr(input opcode_t op, input logic [31:0] a,
                               input logic [31:0] b, input logic [15:0] im);
        @(posedge clk);
        #1;
        valid  = 1'b1;
        opcode = op;
        rs     = a;
        rt     = b;
        imm    = im;
    endtask

    // operands keep moving so that ignored inputs really are ignored
    task automatic idle_cycle();
        @(posedge clk);
        #1;
        valid = 1'b0;
        rs    = rand32();
    endtask

    task automatic branch_pair(input opcode_t on_set, input opcode_t on_clear);
        logic [31:0] r;
        r = rand32();
        issue_instr(on_set, r, 32'h0, r[15:0]);
        issue_instr(on_clear, r, 32'h0, r[31:16]);
    endtask

    task automatic start_test();
        test_errs = err_count;
    endtask

    task automatic finish_test(input string name);
        idle_cycle();
        idle_cycle();   // let the last checks land
        if (err_count == test_errs)
        begin
            tests_ok++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_bad++;
            $display("test %s: %0d errors", name, err_count - test_errs);
        end
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: run passed %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin : main
        logic [31:0]           r;
        logic [31:0]           a;
        logic [31:0]           b;
        logic [addr_width-1:0] link;
        clk    = 1'b0;
        rst    = 1'b1;
        valid  = 1'b0;
        opcode = op_add;
        rs     = '0;
        rt     = '0;
        imm    = '0;

        start_test();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        finish_test("reset state");

        start_test();
        for (int i = 0; i < 200; i++)
        begin
            r = rand32();
            a = rand32();
            b = (r[3:0] == 4'h0) ? a : rand32();    // equal operands now and then
            if (r[31:29] == 3'd7)
                issue_instr(op_sub, a, b, r[15:0]);
            else
                issue_instr(opcode_t'({3'b000, r[31:29]}), a, b, r[15:0]);
        end
        finish_test("random arithmetic");

        start_test();
        issue_instr(op_sub, 32'h1234_5678, 32'h1234_5678, 16'h0);  // zero set
        branch_pair(op_bz, op_bnz);
        issue_instr(op_add, 32'd1, 32'd1, 16'h0);                   // all clear
        branch_pair(op_bz, op_bnz);
        issue_instr(op_add, 32'hffff_ffff, 32'd1, 16'h0);           // carry out
        branch_pair(op_bc, op_bnc);
        issue_instr(op_add, 32'd1, 32'd1, 16'h0);
        branch_pair(op_bc, op_bnc);
        issue_instr(op_sub, 32'd0, 32'd1, 16'h0);                   // negative
        branch_pair(op_bs, op_bns);
        issue_instr(op_add, 32'd1, 32'd1, 16'h0);
        branch_pair(op_bs, op_bns);
        issue_instr(op_add, 32'h7fff_ffff, 32'd1, 16'h0);           // signed overflow
        branch_pair(op_bo, op_bno);
        issue_instr(op_add, 32'd1, 32'd1, 16'h0);
        branch_pair(op_bo, op_bno);
        finish_test("conditional branches");

        start_test();
        for (int i = 0; i < 4; i++)
        begin
            r = rand32();
            issue_instr(op_jmp, r, 32'h0, r[15:0]);
            r = rand32();
            issue_instr(op_jr, r, 32'h0, r[31:16]);
        end
        finish_test("unconditional branches");

        start_test();
        repeat (2)
        begin
            r = rand32();
            issue_instr(op_call, 32'h0, 32'h0, r[15:0]);
            issue_instr(op_add, r, 32'h5, 16'h0);
            link = m_link_addr;     // model has taken the call by now
            idle_cycle();
            issue_instr(op_ret, {16'h0, link}, 32'h0, 16'h0);
        end
        finish_test("call and return");

        start_test();
        issue_instr(op_sub, 32'h0, 32'h1, 16'h0);   // c and s set
        idle_cycle();
        idle_cycle();
        issue_instr(op_jmp, 32'h0, 32'h0, 16'h0010);
        issue_instr(op_bc, 32'h0, 32'h0, 16'h0020);
        idle_cycle();
        issue_instr(opcode_t'(6'h3f), 32'h0, 32'h0, 16'h0);  // no-op encoding
        issue_instr(op_bs, 32'h0, 32'h0, 16'h0030);
        issue_instr(op_bz, 32'h0, 32'h0, 16'h0040);
        idle_cycle();
        idle_cycle();
        issue_instr(op_bno, 32'h0, 32'h0, 16'hfff0);
        finish_test("flag hold");

        $display("tests ok %0d, tests failed %0d, check errors %0d",
                 tests_ok, tests_bad, err_count);
        if (tests_bad == 0 && err_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
